/* source/core_pkg.sv */
// Core shared definitions
package core_pkg;

    localparam int data_width = 32;
    localparam int reg_index_width = 5;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------

    // major opcodes; opc_other stands in for anything unsupported
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_other  = 7'b1111111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jump
    } branch_e;

    // write-back source
    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_e;

    // --------------------------------------------------
    // stage payloads
    // --------------------------------------------------

    typedef struct packed {
        logic [data_width-1:0] pc;
        logic [data_width-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic [data_width-1:0]      pc;
        logic [data_width-1:0]      rs1_value;
        logic [data_width-1:0]      rs2_value;
        logic [data_width-1:0]      imm;
        logic [reg_index_width-1:0] rd;
        alu_op_e                    alu_op;
        logic                       use_imm;
        branch_e                    branch;
        logic                       load;
        logic                       store;
        wb_sel_e                    wb_sel;
    } decoded_t;

    typedef struct packed {
        logic [data_width-1:0]      pc;
        logic [data_width-1:0]      result;
        logic [data_width-1:0]      store_data;
        logic [reg_index_width-1:0] rd;
        logic                       taken;
        logic [data_width-1:0]      target;
        logic                       load;
        logic                       store;
        wb_sel_e                    wb_sel;
    } executed_t;

    typedef struct packed {
        logic [data_width-1:0] addr;
        logic                  write;
        logic [data_width-1:0] wdata;
    } dmem_req_t;

endpackage

/* source/fetch_stage.sv */
// Instruction fetch
module fetch_stage #(
    parameter int addr_width = 17
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            retire,
    input  logic [core_pkg::data_width-1:0] next_pc,
    output logic                            imem_req,
    output logic [addr_width-1:0]           imem_addr,
    input  logic                            imem_valid,
    input  logic [core_pkg::data_width-1:0] imem_rdata,
    output logic                            out_valid,
    output core_pkg::fetch_t                out
);
    import core_pkg::*;

    logic [data_width-1:0] pc;
    // first fetch after reset
    logic boot;

    assign imem_addr = pc[addr_width-1:0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc        <= '0;
            imem_req  <= 1'b0;
            boot      <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            boot      <= 1'b0;
            out_valid <= imem_req && imem_valid;
            if (retire) begin
                pc <= next_pc;
            end
            if (boot || retire) begin
                imem_req <= 1'b1;
            end else if (imem_valid) begin
                imem_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req && imem_valid) begin
            out.pc    <= pc;
            out.instr <= imem_rdata;
        end
    end

    // memory answers only a pending request
    a_valid_needs_req: assert property (@(posedge clk) disable iff (!rst)
        imem_valid |-> imem_req);

    // one instruction in flight, so nothing retires while fetching
    a_no_retire_in_fetch: assert property (@(posedge clk) disable iff (!rst)
        retire |-> !imem_req);

endmodule

/* source/decode_stage.sv */
// Instruction decode
module decode_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  core_pkg::fetch_t                     in,
    output logic [core_pkg::reg_index_width-1:0] rs1_index,
    output logic [core_pkg::reg_index_width-1:0] rs2_index,
    input  logic [core_pkg::data_width-1:0]      rs1_data,
    input  logic [core_pkg::data_width-1:0]      rs2_data,
    output logic                                 out_valid,
    output core_pkg::decoded_t                   out
);
    import core_pkg::*;

    logic [data_width-1:0] instr;
    logic [2:0] funct3;
    opcode_e opcode;
    decoded_t dec;

    // --------------------------------------------------
    // field extraction
    // --------------------------------------------------
    assign instr     = in.instr;
    assign funct3    = instr[14:12];
    assign rs1_index = instr[19:15];
    assign rs2_index = instr[24:20];

    always_comb begin
        case (instr[6:0])
            opc_op, opc_op_imm, opc_load, opc_store, opc_branch, opc_jal: begin
                opcode = opcode_e'(instr[6:0]);
            end
            default: opcode = opc_other;
        endcase
    end

    // --------------------------------------------------
    // control and immediate
    // --------------------------------------------------
    always_comb begin
        dec           = '0;
        dec.pc        = in.pc;
        dec.rs1_value = rs1_data;
        dec.rs2_value = rs2_data;
        dec.rd        = instr[11:7];
        dec.alu_op    = alu_add;
        dec.branch    = br_none;
        dec.wb_sel    = wb_none;
        case (opcode)
            opc_op: begin
                dec.wb_sel = wb_alu;
                case (funct3)
                    3'b000:  dec.alu_op = instr[30] ? alu_sub : alu_add;
                    3'b111:  dec.alu_op = alu_and;
                    3'b110:  dec.alu_op = alu_or;
                    3'b100:  dec.alu_op = alu_xor;
                    3'b010:  dec.alu_op = alu_slt;
                    default: dec.wb_sel = wb_none;
                endcase
            end
            opc_op_imm: begin
                // only addi, the rest retire as no-ops
                dec.imm     = {{20{instr[31]}}, instr[31:20]};
                dec.use_imm = 1'b1;
                dec.wb_sel  = (funct3 == 3'b000) ? wb_alu : wb_none;
            end
            opc_load: begin
                dec.imm     = {{20{instr[31]}}, instr[31:20]};
                dec.use_imm = 1'b1;
                dec.load    = 1'b1;
                dec.wb_sel  = wb_mem;
            end
            opc_store: begin
                dec.imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec.use_imm = 1'b1;
                dec.store   = 1'b1;
            end
            opc_branch: begin
                dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    dec.branch = br_beq;
                end else if (funct3 == 3'b001) begin
                    dec.branch = br_bne;
                end
            end
            opc_jal: begin
                dec.imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
                dec.branch = br_jump;
                dec.wb_sel = wb_pc_plus4;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= dec;
        end
    end

endmodule

/* source/register_file.sv */
// General purpose register file
module register_file (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [core_pkg::reg_index_width-1:0] rs1_index,
    input  logic [core_pkg::reg_index_width-1:0] rs2_index,
    output logic [core_pkg::data_width-1:0]      rs1_data,
    output logic [core_pkg::data_width-1:0]      rs2_data,
    input  logic                                 write_enable,
    input  logic [core_pkg::reg_index_width-1:0] rd_index,
    input  logic [core_pkg::data_width-1:0]      write_data
);
    import core_pkg::*;

    // x0 has no storage
    logic [data_width-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd_index != '0) begin
            regs[rd_index] <= write_data;
        end
    end

    // combinational reads
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_index != '0) begin
            rs1_data = regs[rs1_index];
        end
        if (rs2_index != '0) begin
            rs2_data = regs[rs2_index];
        end
    end

endmodule

/* source/execute_stage.sv */
// ALU and branch resolution
module execute_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  core_pkg::decoded_t  in,
    output logic                out_valid,
    output core_pkg::executed_t out
);
    import core_pkg::*;

    logic [data_width-1:0] op_b;
    logic [data_width-1:0] result;
    logic taken;

    assign op_b = in.use_imm ? in.imm : in.rs2_value;

    // loads and stores ride on alu_add for the address
    always_comb begin
        case (in.alu_op)
            alu_add: result = in.rs1_value + op_b;
            alu_sub: result = in.rs1_value - op_b;
            alu_and: result = in.rs1_value & op_b;
            alu_or:  result = in.rs1_value | op_b;
            alu_xor: result = in.rs1_value ^ op_b;
            alu_slt: begin
                result = {{(data_width-1){1'b0}},
                          $signed(in.rs1_value) < $signed(op_b)};
            end
            default: result = '0;
        endcase
    end

    always_comb begin
        case (in.branch)
            br_beq:  taken = in.rs1_value == in.rs2_value;
            br_bne:  taken = in.rs1_value != in.rs2_value;
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out.pc         <= in.pc;
            out.result     <= result;
            out.store_data <= in.rs2_value;
            out.rd         <= in.rd;
            out.taken      <= taken;
            out.target     <= in.pc + in.imm;
            out.load       <= in.load;
            out.store      <= in.store;
            out.wb_sel     <= in.wb_sel;
        end
    end

endmodule

/* source/memory_writeback_stage.sv */
// Memory access, write-back and retire
module memory_writeback_stage #(
    parameter int addr_width = 17
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  core_pkg::executed_t                  in,
    output logic                                 dmem_req,
    output core_pkg::dmem_req_t                  dmem_cmd,
    input  logic                                 dmem_done,
    input  logic [core_pkg::data_width-1:0]      dmem_rdata,
    output logic                                 write_enable,
    output logic [core_pkg::reg_index_width-1:0] rd_index,
    output logic [core_pkg::data_width-1:0]      write_data,
    output logic                                 retire,
    output logic [core_pkg::data_width-1:0]      next_pc
);
    import core_pkg::*;

    typedef enum logic {
        st_idle,
        st_wait
    } state_e;

    state_e state;
    logic mem_op;
    logic [data_width-1:0] pc_plus4;

    assign mem_op   = in.load || in.store;
    assign pc_plus4 = in.pc + 32'd4;

    // --------------------------------------------------
    // data request
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= st_idle;
            dmem_req <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid && mem_op) begin
                        state    <= st_wait;
                        dmem_req <= 1'b1;
                    end
                end
                st_wait: begin
                    if (dmem_done) begin
                        state    <= st_idle;
                        dmem_req <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && in_valid && mem_op) begin
            dmem_cmd.addr  <= {{(data_width-addr_width){1'b0}}, in.result[addr_width-1:0]};
            dmem_cmd.write <= in.store;
            dmem_cmd.wdata <= in.store_data;
        end
    end

    // --------------------------------------------------
    // write-back and retire
    // --------------------------------------------------
    // execute holds its payload until the next instruction, so in stays valid while waiting
    assign retire = (state == st_idle && in_valid && !mem_op) ||
                    (state == st_wait && dmem_done);
    assign write_enable = retire && in.wb_sel != wb_none;
    assign rd_index     = in.rd;
    assign next_pc      = in.taken ? in.target : pc_plus4;

    always_comb begin
        case (in.wb_sel)
            wb_alu:      write_data = in.result;
            wb_mem:      write_data = dmem_rdata;
            wb_pc_plus4: write_data = pc_plus4;
            default:     write_data = '0;
        endcase
    end

    // held request still matches the instruction waiting to retire
    a_req_stable: assert property (@(posedge clk) disable iff (!rst)
        state == st_wait |-> dmem_cmd.write == in.store &&
            dmem_cmd.wdata == in.store_data &&
            dmem_cmd.addr[addr_width-1:0] == in.result[addr_width-1:0]);

endmodule

/* source/core_top.sv */
// RV32I core top level
module core_top #(
    parameter int addr_width = 17
) (
    input  logic                            clk,
    input  logic                            rst,
    output logic                            imem_req,
    output logic [addr_width-1:0]           imem_addr,
    input  logic                            imem_valid,
    input  logic [core_pkg::data_width-1:0] imem_rdata,
    output logic                            dmem_req,
    output core_pkg::dmem_req_t             dmem_cmd,
    input  logic                            dmem_done,
    input  logic [core_pkg::data_width-1:0] dmem_rdata
);
    import core_pkg::*;

    logic fetch_valid;
    fetch_t fetch_out;
    logic decode_valid;
    decoded_t decode_out;
    logic exec_valid;
    executed_t exec_out;

    // register file ports
    logic [reg_index_width-1:0] rs1_index;
    logic [reg_index_width-1:0] rs2_index;
    logic [data_width-1:0] rs1_data;
    logic [data_width-1:0] rs2_data;
    logic rf_write_enable;
    logic [reg_index_width-1:0] rf_rd_index;
    logic [data_width-1:0] rf_write_data;

    // retire loop back to fetch
    logic retire;
    logic [data_width-1:0] next_pc;

    fetch_stage #(.addr_width(addr_width)) u_fetch (
        .clk(clk), .rst(rst), .retire(retire), .next_pc(next_pc),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .out_valid(fetch_valid), .out(fetch_out)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .in_valid(fetch_valid), .in(fetch_out),
        .rs1_index(rs1_index), .rs2_index(rs2_index),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .out_valid(decode_valid), .out(decode_out)
    );

    register_file u_regs (
        .clk(clk), .rst(rst),
        .rs1_index(rs1_index), .rs2_index(rs2_index),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .write_enable(rf_write_enable), .rd_index(rf_rd_index),
        .write_data(rf_write_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .in_valid(decode_valid), .in(decode_out),
        .out_valid(exec_valid), .out(exec_out)
    );

    memory_writeback_stage #(.addr_width(addr_width)) u_memwb (
        .clk(clk), .rst(rst), .in_valid(exec_valid), .in(exec_out),
        .dmem_req(dmem_req), .dmem_cmd(dmem_cmd),
        .dmem_done(dmem_done), .dmem_rdata(dmem_rdata),
        .write_enable(rf_write_enable), .rd_index(rf_rd_index),
        .write_data(rf_write_data), .retire(retire), .next_pc(next_pc)
    );

endmodule

/* dv/core_tb_memory.sv */
// Instruction and data memory model
module core_tb_memory #(
    parameter int addr_width = 17
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            imem_req,
    input  logic [addr_width-1:0]           imem_addr,
    output logic                            imem_valid,
    output logic [core_pkg::data_width-1:0] imem_rdata,
    input  logic                            dmem_req,
    input  core_pkg::dmem_req_t             dmem_cmd,
    output logic                            dmem_done,
    output logic [core_pkg::data_width-1:0] dmem_rdata,
    output logic                            finished
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    // last data word, written by every program when it ends
    localparam logic [9:0] final_index = 10'h3ff;

    logic [data_width-1:0] imem [1024];
    logic [data_width-1:0] dmem [1024];

    // cycles left before the answer, 0 when idle
    int imem_wait;
    int dmem_wait;

    initial begin
        imem_valid = 1'b0;
        imem_rdata = '0;
        dmem_done  = 1'b0;
        dmem_rdata = '0;
        finished   = 1'b0;
        imem_wait  = 0;
        dmem_wait  = 0;
    end

    // --------------------------------------------------
    // instruction port
    // --------------------------------------------------
    // updates on the falling edge, the core samples on the rising one
    always @(negedge clk) begin
        if (!rst) begin
            imem_valid = 1'b0;
            imem_wait  = 0;
        end else begin
            imem_valid = 1'b0;
            if (imem_wait == 1) begin
                imem_valid = 1'b1;
                imem_rdata = imem[imem_addr[11:2]];
                imem_wait  = 0;
            end else if (imem_wait > 1) begin
                imem_wait--;
            end else if (imem_req) begin
                imem_wait = 1 + int'($urandom % 4);
            end
        end
    end

    // --------------------------------------------------
    // data port
    // --------------------------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            dmem_done = 1'b0;
            dmem_wait = 0;
            finished  = 1'b0;
        end else begin
            dmem_done = 1'b0;
            if (dmem_wait == 1) begin
                dmem_done = 1'b1;
                dmem_wait = 0;
                if (dmem_cmd.write) begin
                    dmem[dmem_cmd.addr[11:2]] = dmem_cmd.wdata;
                    if (dmem_cmd.addr[11:2] == final_index) begin
                        finished = 1'b1;
                    end
                end else begin
                    dmem_rdata = dmem[dmem_cmd.addr[11:2]];
                end
            end else if (dmem_wait > 1) begin
                dmem_wait--;
            end else if (dmem_req) begin
                dmem_wait = 1 + int'($urandom % 4);
            end
        end
    end

endmodule

/* dv/core_tb.sv */
// Core directed testbench
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    localparam int addr_width = 17;
    localparam int timeout_cycles = 2000;
    localparam int mem_words = 1024;

    logic clk;
    logic rst;
    logic imem_req;
    logic [addr_width-1:0] imem_addr;
    logic imem_valid;
    logic [data_width-1:0] imem_rdata;
    logic dmem_req;
    dmem_req_t dmem_cmd;
    logic dmem_done;
    logic [data_width-1:0] dmem_rdata;
    logic finished;

    int prog_len;
    int test_errors;
    int tests_passed;
    int tests_failed;

    core_tb_memory #(.addr_width(addr_width)) u_mem (
        .clk(clk), .rst(rst),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_cmd(dmem_cmd),
        .dmem_done(dmem_done), .dmem_rdata(dmem_rdata),
        .finished(finished)
    );

    core_top #(.addr_width(addr_width)) DUT (
        .clk(clk), .rst(rst),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_cmd(dmem_cmd),
        .dmem_done(dmem_done), .dmem_rdata(dmem_rdata)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // memory setup and program assembly
    // --------------------------------------------------
    // untouched data words, so skipped stores stay visible
    function automatic logic [31:0] data_fill(input logic [31:0] addr);
        return 32'h5a00_0000 ^ addr ^ (addr << 16);
    endfunction

    task automatic poke_word(input logic [31:0] addr, input logic [31:0] value);
        u_mem.dmem[addr[11:2]] = value;
    endtask

    task automatic start_program;
        logic [31:0] addr;
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        for (int i = 0; i < mem_words; i++) begin
            addr = 32'(i) << 2;
            u_mem.dmem[addr[11:2]] = data_fill(addr);
            // unsupported opcode carrying the word address
            u_mem.imem[addr[11:2]] = {addr[26:2], 7'b111_1111};
        end
        prog_len = 0;
        test_errors = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        logic [31:0] addr;
        addr = 32'(prog_len) << 2;
        u_mem.imem[addr[11:2]] = word;
        prog_len++;
    endtask

    task automatic addi(input int rd, input int rs1, input int imm);
        emit({imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b001_0011});
    endtask

    task automatic alu_rr(input int f7, input int f3, input int rd, input int rs1, input int rs2);
        emit({f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b011_0011});
    endtask

    // loads and stores address off x0
    task automatic lw(input int rd, input int offset);
        emit({offset[11:0], 5'd0, 3'b010, rd[4:0], 7'b000_0011});
    endtask

    task automatic sw(input int rs2, input int offset);
        emit({offset[11:5], rs2[4:0], 5'd0, 3'b010, offset[4:0], 7'b010_0011});
    endtask

    task automatic branch(input int f3, input int rs1, input int rs2, input int offset);
        emit({offset[12], offset[10:5], rs2[4:0], rs1[4:0], f3[2:0], offset[4:1],
              offset[11], 7'b110_0011});
    endtask

    task automatic jal(input int rd, input int offset);
        emit({offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'b110_1111});
    endtask

    // store to the last data word, then spin in place
    task automatic end_program;
        sw(0, -4);
        jal(0, 0);
    endtask

    // --------------------------------------------------
    // run and check
    // --------------------------------------------------
    task automatic run_program(input string name);
        int cycles;
        repeat (2) @(negedge clk);
        rst = 1'b1;
        cycles = 0;
        while (!finished && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        assert (finished) else begin
            $display("%s: the program never finished within %0d cycles", name, timeout_cycles);
            test_errors++;
        end
    endtask

    task automatic expect_word(input logic [31:0] addr, input logic [31:0] expected);
        logic [31:0] actual;
        actual = u_mem.dmem[addr[11:2]];
        assert (actual === expected) else begin
            $display("Error: dmem[%h] expected %h, actual %h", addr, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic alu_ops;
        logic [31:0] a;
        logic [31:0] b;
        a = 32'd1234;
        b = -32'sd300;
        start_program();
        addi(1, 0, 1234);
        addi(2, 0, -300);
        alu_rr(0, 0, 3, 1, 2);
        alu_rr(32, 0, 4, 1, 2);
        alu_rr(0, 7, 5, 1, 2);
        alu_rr(0, 6, 6, 1, 2);
        alu_rr(0, 4, 7, 1, 2);
        // slt both ways round the negative operand
        alu_rr(0, 2, 8, 2, 1);
        alu_rr(0, 2, 9, 1, 2);
        for (int r = 1; r <= 9; r++) begin
            sw(r, 'h100 + 4 * (r - 1));
        end
        end_program();
        run_program("alu_ops");
        expect_word(32'h100, a);
        expect_word(32'h104, b);
        expect_word(32'h108, a + b);
        expect_word(32'h10c, a - b);
        expect_word(32'h110, a & b);
        expect_word(32'h114, a | b);
        expect_word(32'h118, a ^ b);
        expect_word(32'h11c, {31'b0, $signed(b) < $signed(a)});
        expect_word(32'h120, {31'b0, $signed(a) < $signed(b)});
        report("alu_ops");
    endtask

    task automatic loads_and_stores;
        logic [31:0] w [3];
        logic [31:0] sum;
        start_program();
        sum = '0;
        for (int i = 0; i < 3; i++) begin
            w[i] = $urandom;
            poke_word(32'h200 + 32'(4 * i), w[i]);
            sum += w[i];
        end
        lw(1, 'h200);
        lw(2, 'h204);
        lw(3, 'h208);
        alu_rr(0, 0, 4, 1, 2);
        alu_rr(0, 0, 4, 4, 3);
        sw(1, 'h300);
        sw(2, 'h304);
        sw(3, 'h308);
        sw(4, 'h30c);
        end_program();
        run_program("loads_and_stores");
        expect_word(32'h300, w[0]);
        expect_word(32'h304, w[1]);
        expect_word(32'h308, w[2]);
        expect_word(32'h30c, sum);
        report("loads_and_stores");
    endtask

    task automatic branches;
        start_program();
        addi(1, 0, 5);
        addi(2, 0, 5);
        addi(3, 0, 7);
        addi(10, 0, 'h55);
        // beq taken, then bne not taken
        branch(0, 1, 2, 8);
        sw(10, 'h400);
        sw(10, 'h404);
        branch(1, 1, 2, 8);
        sw(10, 'h408);
        // bne taken, then beq not taken
        branch(1, 1, 3, 8);
        sw(10, 'h40c);
        branch(0, 1, 3, 8);
        sw(10, 'h410);
        end_program();
        run_program("branches");
        expect_word(32'h400, data_fill(32'h400));
        expect_word(32'h404, 32'h55);
        expect_word(32'h408, 32'h55);
        expect_word(32'h40c, data_fill(32'h40c));
        expect_word(32'h410, 32'h55);
        report("branches");
    endtask

    task automatic jump_and_link;
        logic [31:0] jal_pc;
        start_program();
        addi(10, 0, 'h66);
        jal_pc = 32'(prog_len) << 2;
        jal(5, 8);
        sw(10, 'h500);
        sw(5, 'h504);
        sw(10, 'h508);
        end_program();
        run_program("jump_and_link");
        expect_word(32'h500, data_fill(32'h500));
        expect_word(32'h504, jal_pc + 32'd4);
        expect_word(32'h508, 32'h66);
        report("jump_and_link");
    endtask

    task automatic zero_and_unknown;
        start_program();
        addi(0, 0, 123);
        addi(1, 0, 77);
        // lui and a custom opcode, both aimed at x1
        emit({20'h003ff, 5'd1, 7'b011_0111});
        emit({20'habcde, 5'd1, 7'b000_1011});
        alu_rr(0, 0, 0, 1, 1);
        sw(0, 'h600);
        sw(1, 'h604);
        end_program();
        run_program("zero_and_unknown");
        expect_word(32'h600, 32'h0);
        expect_word(32'h604, 32'd77);
        report("zero_and_unknown");
    endtask

    initial begin
        void'($urandom(13983));
        clk = 1'b0;
        rst = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        alu_ops();
        loads_and_stores();
        branches();
        jump_and_link();
        zero_and_unknown();
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sources.f */
source/core_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/memory_writeback_stage.sv
source/core_top.sv
dv/core_tb_memory.sv
dv/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module core_tb -Mdir obj_dir -f sources.f || exit 1
output=$(./obj_dir/Vcore_tb)
echo "$output"
echo "$output" | grep -q "^Done: no errors$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
